// ==== sim.f ====
+incdir+source
source/led_driver_pkg.sv
source/shift_enable_gen.sv
source/driver_config_reg.sv
source/column_buffer.sv
source/driver_sequencer.sv
source/led_driver_top.sv
dv/led_driver_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
   -f sim.f \
   --top-module led_driver_tb \
   -Mdir obj_dir \
   -o led_driver_sim

./obj_dir/led_driver_sim > sim.log
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
   exit 0
fi
echo "Testbench reported failure, see sim.log"
exit 1

// ==== dv/led_driver_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_driver_params.svh"

module led_driver_tb;

   localparam int NCH = `LED_NUM_CHANNELS;
   localparam int WB = `LED_WORD_BITS;
   localparam int SEGS = `LED_SEGMENTS_PER_LINE;
   localparam int SLICE_BITS = `LED_LINES_PER_SLICE * SEGS * WB;
   // Enabled cycles from reset release through the idle bank swap
   localparam int BOOT_E = 1 + 15 + (WB + 1) + 6 + 11 + (WB + 5) + `LED_GCLK_IDLE + 1;
   localparam int SLICE_E = `LED_LINES_PER_SLICE * (`LED_BLANKING_TIME + SEGS * (WB + 1))
      + `LED_GCLK_IDLE + 1;
   localparam int LIMIT = 4 * (BOOT_E + 2 * SLICE_E) * `LED_CLK_DIV;
   // GCLK without SCLK per slice, blanking less its first cycle plus one pause per segment
   localparam int GCLK_ONLY = `LED_LINES_PER_SLICE * (`LED_BLANKING_TIME - 1 + SEGS);

   // LED number sent at each step of a segment, step 0 first
   localparam int RG_L0 [16] = '{6, 7, 9, 8, 10, 11, 13, 12, 14, 15, 1, 0, 2, 3, 5, 4};
   localparam int B_L0 [16] = '{8, 9, 14, 15, 12, 13, 2, 3, 0, 1, 6, 7, 4, 5, 10, 11};
   localparam int RG_L1 [16] = '{2, 3, 5, 4, 6, 7, 9, 8, 10, 11, 13, 12, 14, 15, 1, 0};
   localparam int B_L1 [16] = '{0, 1, 6, 7, 4, 5, 9, 11, 8, 10, 14, 15, 12, 13, 2, 3};

   logic clk;
   logic nrst;
   logic wr_en;
   led_driver_pkg::chan_idx_t wr_chan;
   led_driver_pkg::word_t wr_data;
   logic conf_wr;
   led_driver_pkg::word_t conf_data;
   logic position_sync;
   logic driver_sclk;
   logic driver_gclk;
   logic driver_lat;
   logic [NCH-1:0] drivers_sin;
   logic column_ready;

   integer seed;
   int err_cnt;
   int cycle_cnt;
   // Words the host puts in both banks
   led_driver_pkg::word_t chan_words [NCH];
   // Running counts, cleared at the start of each phase
   logic prev_cr;
   int cr_rises;
   int gclk_cnt;
   int gclk_only;
   int sclk_cnt;

   led_driver_top UUT (
      .clk (clk),
      .nrst (nrst),
      .wr_en (wr_en),
      .wr_chan (wr_chan),
      .wr_data (wr_data),
      .conf_wr (conf_wr),
      .conf_data (conf_data),
      .position_sync (position_sync),
      .driver_sclk (driver_sclk),
      .driver_gclk (driver_gclk),
      .driver_lat (driver_lat),
      .drivers_sin (drivers_sin),
      .column_ready (column_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Watchdog sized from boot plus two slices
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < LIMIT) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d clock cycles, DUT stopped making progress (%0d errors)",
         LIMIT, err_cnt);
      $display("Simulation FAILED");
      $finish;
   end

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         err_cnt++;
         $display("ERR %0t %s expected %0h got %0h in %s", $time, name, exp, act,
            UUT.u_driver_sequencer.state.name());
      end
   endtask

   task automatic clear_counts();
      prev_cr = column_ready;
      cr_rises = 0;
      gclk_cnt = 0;
      gclk_only = 0;
      sclk_cnt = 0;
   endtask

   // Sample just after the falling edge, LAT has settled and SCLK is mid-pulse
   task automatic step();
      @(negedge clk);
      #1;
      if (column_ready && !prev_cr) begin
         cr_rises++;
      end
      prev_cr = column_ready;
      if (driver_gclk) begin
         gclk_cnt++;
      end
      if (driver_gclk && !driver_sclk) begin
         gclk_only++;
      end
      if (driver_sclk) begin
         sclk_cnt++;
      end
   endtask

   task automatic wait_sclk();
      do begin
         step();
      end while (!driver_sclk);
   endtask

   // Next LAT-high stretch, counts SCLK pulses inside it
   task automatic count_lat_sclk(output int n);
      n = 0;
      do begin
         step();
      end while (!driver_lat);
      while (driver_lat) begin
         if (driver_sclk) begin
            n++;
         end
         step();
      end
   endtask

   task automatic write_channel(input int ch, input led_driver_pkg::word_t data);
      @(negedge clk);
      wr_en = 1'b1;
      wr_chan = led_driver_pkg::chan_idx_t'(ch);
      wr_data = data;
      @(negedge clk);
      wr_en = 1'b0;
   endtask

   task automatic write_conf(input led_driver_pkg::word_t data);
      @(negedge clk);
      conf_wr = 1'b1;
      conf_data = data;
      @(negedge clk);
      conf_wr = 1'b0;
   endtask

   // Held one enable period so exactly one enabled edge sees it
   task automatic pulse_sync();
      @(negedge clk);
      position_sync = 1'b1;
      repeat (`LED_CLK_DIV) @(negedge clk);
      position_sync = 1'b0;
   endtask

   task automatic fill_back_bank();
      for (int ch = 0; ch < NCH; ch++) begin
         write_channel(ch, chan_words[ch]);
      end
   endtask

   // SIN of one chip at bit k of a segment, three colour bits per LED step
   function automatic logic expected_sin(input int ch, input int k);
      int led_step;
      int colour;
      int led;
      logic [5:0] bit_idx;
      led_step = k / 3;
      colour = k % 3;
      if (ch >= 10 && ch < 20) begin
         led = (colour == 0) ? B_L0[led_step] : RG_L0[led_step];
      end else begin
         led = (colour == 0) ? B_L1[led_step] : RG_L1[led_step];
      end
      bit_idx = 6'(3 * led + colour);
      return chan_words[ch][bit_idx];
   endfunction

   // Next 48 SCLK bits carry the word MSB first, WRTFC on the last five
   task automatic check_conf_shift(input led_driver_pkg::word_t w);
      logic [NCH-1:0] exp_sin;
      for (int k = 0; k < WB; k++) begin
         wait_sclk();
         exp_sin = {NCH{w[6'(WB - 1 - k)]}};
         check("drivers_sin", 64'(exp_sin), 64'(drivers_sin));
         check("driver_lat", 64'(k >= WB - 5), 64'(driver_lat));
      end
   endtask

   // Every SCLK bit of a slice, data plus WRTGS/LATGS and column_ready position
   task automatic check_slice();
      logic [NCH-1:0] exp_sin;
      int k;
      int s;
      for (int n = 0; n < SLICE_BITS; n++) begin
         wait_sclk();
         k = n % WB;
         s = (n / WB) % SEGS;
         for (int ch = 0; ch < NCH; ch++) begin
            exp_sin[ch] = expected_sin(ch, k);
         end
         check("drivers_sin", 64'(exp_sin), 64'(drivers_sin));
         check("driver_lat", 64'((k == WB - 1) || (s == SEGS - 1 && k >= WB - 3)),
            64'(driver_lat));
         check("column_ready", 64'(s == SEGS - 1 && k == WB - 1), 64'(column_ready));
      end
   endtask

   // FCWRTEN, default word, then READFC
   task automatic test_boot();
      int n;
      count_lat_sclk(n);
      check("sclk_under_fcwrten", 64'(15), 64'(n));
      check_conf_shift(`LED_DEFAULT_CONF);
      count_lat_sclk(n);
      check("sclk_under_readfc", 64'(11), 64'(n));
   endtask

   // Both banks get the same words so all eight lines look alike
   task automatic test_channel_data();
      logic [63:0] rnd;
      for (int ch = 0; ch < NCH; ch++) begin
         rnd = {$random(seed), $random(seed)};
         chan_words[ch] = rnd[WB-1:0];
      end
      chan_words[0] = '1;
      chan_words[1] = '0;
      chan_words[10] = '1;
      chan_words[11] = '0;
      // One-hot words at 3*t+c on both layouts
      chan_words[3] = 48'(1) << (3 * 9);
      chan_words[12] = 48'(1) << (3 * 5 + 1);
      chan_words[14] = 48'(1) << 2;
      chan_words[25] = 48'(1) << (3 * 15 + 2);
      fill_back_bank();
      // Idle swap at the 512th WAIT cycle
      clear_counts();
      do begin
         step();
      end while (!column_ready);
      do begin
         step();
      end while (column_ready);
      fill_back_bank();
      clear_counts();
      pulse_sync();
      check_slice();
      check("column_ready_pulses", 64'(`LED_LINES_PER_SLICE), 64'(cr_rises));
      check("gclk_without_sclk", 64'(GCLK_ONLY), 64'(gclk_only));
   endtask

   task automatic test_idle();
      clear_counts();
      repeat ((`LED_GCLK_IDLE + 64) * `LED_CLK_DIV) step();
      check("idle_gclk", 64'(`LED_GCLK_IDLE), 64'(gclk_cnt));
      check("idle_sclk", 64'(0), 64'(sclk_cnt));
      check("idle_column_ready", 64'(1), 64'(cr_rises));
   endtask

   // New word lands mid-segment, LAT is low there
   task automatic test_reconfig();
      logic [63:0] rnd;
      led_driver_pkg::word_t new_conf;
      int n;
      rnd = {$random(seed), $random(seed)};
      new_conf = rnd[WB-1:0];
      pulse_sync();
      repeat (WB + 12) wait_sclk();
      write_conf(new_conf);
      count_lat_sclk(n);
      check("sclk_under_fcwrten", 64'(15), 64'(n));
      check_conf_shift(new_conf);
   endtask

   initial begin
      seed = 32'h5da43217;
      err_cnt = 0;
      nrst = 1'b0;
      wr_en = 1'b0;
      wr_chan = '0;
      wr_data = '0;
      conf_wr = 1'b0;
      conf_data = '0;
      position_sync = 1'b0;
      prev_cr = 1'b0;
      repeat (16) @(negedge clk);
      nrst = 1'b1;
      test_boot();
      test_channel_data();
      test_idle();
      test_reconfig();
      $display("Run complete with %0d errors", err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/led_driver_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_driver_params.svh"

module led_driver_top (
   input wire clk,
   input wire nrst,
   input wire wr_en,
   input wire led_driver_pkg::chan_idx_t wr_chan,
   input wire led_driver_pkg::word_t wr_data,
   input wire conf_wr,
   input wire led_driver_pkg::word_t conf_data,
   input wire position_sync,
   output logic driver_sclk,
   output logic driver_gclk,
   output logic driver_lat,
   output logic [`LED_NUM_CHANNELS-1:0] drivers_sin,
   output logic column_ready
);

   logic clk_enable;
   logic new_configuration_ready;
   led_driver_pkg::word_t serialized_conf;
   led_driver_pkg::word_t data_in [`LED_NUM_CHANNELS];

   // Shift rate for the whole chain
   shift_enable_gen u_shift_enable_gen (
      .clk (clk),
      .nrst (nrst),
      .clk_enable (clk_enable)
   );

   driver_config_reg u_driver_config_reg (
      .clk (clk),
      .nrst (nrst),
      .clk_enable (clk_enable),
      .conf_wr (conf_wr),
      .conf_data (conf_data),
      .serialized_conf (serialized_conf),
      .new_configuration_ready (new_configuration_ready)
   );

   // Bank swap driven back from the sequencer
   column_buffer u_column_buffer (
      .clk (clk),
      .nrst (nrst),
      .clk_enable (clk_enable),
      .wr_en (wr_en),
      .wr_chan (wr_chan),
      .wr_data (wr_data),
      .column_ready (column_ready),
      .data_in (data_in)
   );

   driver_sequencer u_driver_sequencer (
      .clk (clk),
      .clk_enable (clk_enable),
      .nrst (nrst),
      .position_sync (position_sync),
      .serialized_conf (serialized_conf),
      .data_in (data_in),
      .new_configuration_ready (new_configuration_ready),
      .driver_sclk (driver_sclk),
      .driver_gclk (driver_gclk),
      .driver_lat (driver_lat),
      .drivers_sin (drivers_sin),
      .column_ready (column_ready)
   );

endmodule

`default_nettype wire

// ==== source/driver_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_driver_params.svh"

module driver_sequencer (
   input wire clk,
   input wire clk_enable,
   input wire nrst,
   input wire position_sync,
   input wire led_driver_pkg::word_t serialized_conf,
   input wire led_driver_pkg::word_t data_in [`LED_NUM_CHANNELS],
   input wire new_configuration_ready,
   output logic driver_sclk,
   output logic driver_gclk,
   output logic driver_lat,
   output logic [`LED_NUM_CHANNELS-1:0] drivers_sin,
   output logic column_ready
);

   // Counter has to reach one past the idle GCLK run
   localparam int CNT_W = $clog2(`LED_GCLK_IDLE + 2);

   // Latch command lengths in SCLK edges
   localparam int WRTFC_LEN = 5;
   localparam int LATGS_LEN = 3;

   localparam logic [CNT_W-1:0] PREP_CFG_LAST = CNT_W'(14);
   localparam logic [CNT_W-1:0] CFG_LAST = CNT_W'(`LED_WORD_BITS);
   localparam logic [CNT_W-1:0] CFG_LAT_FIRST = CNT_W'(`LED_WORD_BITS + 1 - WRTFC_LEN);
   localparam logic [CNT_W-1:0] WRTFC_LAST = CNT_W'(5);
   localparam logic [CNT_W-1:0] PREP_DUMP_LAST = CNT_W'(10);
   localparam logic [CNT_W-1:0] DUMP_LAST = CNT_W'(`LED_WORD_BITS + 4);
   localparam logic [CNT_W-1:0] DUMP_PAUSE = CNT_W'(5);
   localparam logic [CNT_W-1:0] BLANK_LAST = CNT_W'(`LED_BLANKING_TIME - 1);
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`LED_WORD_BITS - 1);
   localparam logic [CNT_W-1:0] LATGS_FIRST = CNT_W'(`LED_WORD_BITS - LATGS_LEN);
   localparam logic [CNT_W-1:0] IDLE_GCLK = CNT_W'(`LED_GCLK_IDLE);
   localparam logic [CNT_W-1:0] IDLE_LAST = CNT_W'(`LED_GCLK_IDLE + 1);
   localparam logic [3:0] SEG_LAST = 4'(`LED_SEGMENTS_PER_LINE - 1);
   localparam logic [2:0] LINE_LAST = 3'(`LED_LINES_PER_SLICE - 1);

   // Pixel order per chip layout, entry 15 first, holds an LED number
   // Layout 0 is the UB*D0/UB*D2 routing, layout 1 is UB*D1
   localparam logic [15:0][3:0] LUT0_RG = '{
      4'd6, 4'd7, 4'd9, 4'd8, 4'd10, 4'd11, 4'd13, 4'd12,
      4'd14, 4'd15, 4'd1, 4'd0, 4'd2, 4'd3, 4'd5, 4'd4};
   localparam logic [15:0][3:0] LUT0_B = '{
      4'd8, 4'd9, 4'd14, 4'd15, 4'd12, 4'd13, 4'd2, 4'd3,
      4'd0, 4'd1, 4'd6, 4'd7, 4'd4, 4'd5, 4'd10, 4'd11};
   localparam logic [15:0][3:0] LUT1_RG = '{
      4'd2, 4'd3, 4'd5, 4'd4, 4'd6, 4'd7, 4'd9, 4'd8,
      4'd10, 4'd11, 4'd13, 4'd12, 4'd14, 4'd15, 4'd1, 4'd0};
   localparam logic [15:0][3:0] LUT1_B = '{
      4'd0, 4'd1, 4'd6, 4'd7, 4'd4, 4'd5, 4'd9, 4'd11,
      4'd8, 4'd10, 4'd14, 4'd15, 4'd12, 4'd13, 4'd2, 4'd3};

   led_driver_pkg::seq_state_t state;
   logic [CNT_W-1:0] state_cnt;
   logic [3:0] wrtgs_cnt;
   logic [2:0] mux_cnt;
   logic [1:0] rgb_idx;
   logic [3:0] led_idx;
   logic [3:0] led_rev;
   logic [5:0] bit_sel0;
   logic [5:0] bit_sel1;
   logic [5:0] conf_idx;
   logic restart;

   // New configuration only breaks in while streaming or idling
   assign restart = new_configuration_ready &&
      (state == led_driver_pkg::BLANKING || state == led_driver_pkg::WAIT_FOR_NEXT_SLICE ||
       state == led_driver_pkg::PAUSE_SCLK || state == led_driver_pkg::SHIFT_REGISTER);

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         state <= led_driver_pkg::STALL;
         state_cnt <= '0;
         wrtgs_cnt <= '0;
         mux_cnt <= '0;
         rgb_idx <= '0;
         led_idx <= '0;
      end else if (clk_enable) begin
         state_cnt <= state_cnt + 1'b1;
         case (state)
            led_driver_pkg::STALL: begin
               state <= led_driver_pkg::PREPARE_CONFIG;
               state_cnt <= '0;
            end
            // FCWRTEN, 15 edges under LAT
            led_driver_pkg::PREPARE_CONFIG: begin
               if (state_cnt == PREP_CFG_LAST) begin
                  state <= led_driver_pkg::CONFIG;
                  state_cnt <= '0;
               end
            end
            // One quiet cycle, then the word
            led_driver_pkg::CONFIG: begin
               if (state_cnt == CFG_LAST) begin
                  state <= led_driver_pkg::WRTFC_TIMING;
                  state_cnt <= '0;
               end
            end
            led_driver_pkg::WRTFC_TIMING: begin
               if (state_cnt == WRTFC_LAST) begin
                  state <= led_driver_pkg::PREPARE_DUMP_CONFIG;
                  state_cnt <= '0;
               end
            end
            // READFC, 11 edges under LAT
            led_driver_pkg::PREPARE_DUMP_CONFIG: begin
               if (state_cnt == PREP_DUMP_LAST) begin
                  state <= led_driver_pkg::DUMP_CONFIG;
                  state_cnt <= '0;
               end
            end
            led_driver_pkg::DUMP_CONFIG: begin
               if (state_cnt == DUMP_LAST) begin
                  state <= led_driver_pkg::WAIT_FOR_NEXT_SLICE;
                  state_cnt <= '0;
               end
            end
            led_driver_pkg::BLANKING: begin
               wrtgs_cnt <= '0;
               rgb_idx <= '0;
               led_idx <= '0;
               if (state_cnt == BLANK_LAST) begin
                  state <= led_driver_pkg::PAUSE_SCLK;
                  state_cnt <= '0;
               end
            end
            led_driver_pkg::PAUSE_SCLK: begin
               state <= led_driver_pkg::SHIFT_REGISTER;
               state_cnt <= '0;
            end
            led_driver_pkg::SHIFT_REGISTER: begin
               if (state_cnt == BIT_LAST) begin
                  state_cnt <= '0;
                  wrtgs_cnt <= wrtgs_cnt + 1'b1;
                  state <= led_driver_pkg::PAUSE_SCLK;
                  if (wrtgs_cnt == SEG_LAST) begin
                     wrtgs_cnt <= '0;
                     mux_cnt <= mux_cnt + 1'b1;
                     state <= led_driver_pkg::BLANKING;
                     if (mux_cnt == LINE_LAST) begin
                        mux_cnt <= '0;
                        state <= led_driver_pkg::WAIT_FOR_NEXT_SLICE;
                     end
                  end
               end
               // Three colour bits per LED, 16 LEDs per segment
               rgb_idx <= rgb_idx + 1'b1;
               if (rgb_idx == 2'd2) begin
                  rgb_idx <= '0;
                  led_idx <= led_idx + 1'b1;
               end
            end
            led_driver_pkg::WAIT_FOR_NEXT_SLICE: begin
               // Saturates just past the idle GCLK run
               if (state_cnt == IDLE_LAST) begin
                  state_cnt <= state_cnt;
               end
               if (position_sync) begin
                  state <= led_driver_pkg::BLANKING;
                  state_cnt <= '0;
               end
            end
            default: begin
               state <= led_driver_pkg::STALL;
               state_cnt <= '0;
            end
         endcase

         if (restart) begin
            state <= led_driver_pkg::PREPARE_CONFIG;
            state_cnt <= '0;
            wrtgs_cnt <= '0;
            mux_cnt <= '0;
            rgb_idx <= '0;
            led_idx <= '0;
         end
      end
   end

   // SCLK and GCLK are gated copies of the shift enable
   always_comb begin
      driver_sclk = 1'b0;
      driver_gclk = 1'b0;
      case (state)
         led_driver_pkg::CONFIG: driver_sclk = clk_enable && (state_cnt != '0);
         led_driver_pkg::WRTFC_TIMING: driver_sclk = 1'b0;
         led_driver_pkg::DUMP_CONFIG: driver_sclk = clk_enable && (state_cnt >= DUMP_PAUSE);
         led_driver_pkg::WAIT_FOR_NEXT_SLICE: driver_gclk = clk_enable && (state_cnt < IDLE_GCLK);
         led_driver_pkg::BLANKING: driver_gclk = clk_enable && (state_cnt != '0);
         led_driver_pkg::PAUSE_SCLK: driver_gclk = clk_enable;
         led_driver_pkg::SHIFT_REGISTER: begin
            driver_sclk = clk_enable;
            driver_gclk = clk_enable;
         end
         // STALL and both PREPARE states clock the latch commands
         default: driver_sclk = clk_enable;
      endcase
   end

   // LAT moves on the falling edge for hold margin after SCLK
   always_ff @(negedge clk or negedge nrst) begin
      if (!nrst) begin
         driver_lat <= 1'b0;
      end else begin
         case (state)
            led_driver_pkg::PREPARE_CONFIG, led_driver_pkg::PREPARE_DUMP_CONFIG: begin
               driver_lat <= 1'b1;
            end
            // WRTFC over the last five bits
            led_driver_pkg::CONFIG: driver_lat <= (state_cnt >= CFG_LAT_FIRST);
            // WRTGS on the last bit, LATGS closing the tenth segment
            led_driver_pkg::SHIFT_REGISTER: begin
               driver_lat <= (state_cnt == BIT_LAST) ||
                  (state_cnt >= LATGS_FIRST && wrtgs_cnt == SEG_LAST);
            end
            default: driver_lat <= 1'b0;
         endcase
      end
   end

   // Data bit picks, blue table on colour 0
   assign led_rev = 4'd15 - led_idx;
   always_comb begin
      if (rgb_idx == 2'd0) begin
         bit_sel0 = 6'(3 * LUT0_B[led_rev]);
         bit_sel1 = 6'(3 * LUT1_B[led_rev]);
      end else begin
         bit_sel0 = 6'(3 * LUT0_RG[led_rev] + rgb_idx);
         bit_sel1 = 6'(3 * LUT1_RG[led_rev] + rgb_idx);
      end
   end

   // Config word goes out MSB first from the second CONFIG cycle
   assign conf_idx = 6'(`LED_WORD_BITS) - state_cnt[5:0];

   always_comb begin
      drivers_sin = '0;
      case (state)
         led_driver_pkg::CONFIG: begin
            if (state_cnt != '0) begin
               drivers_sin = {`LED_NUM_CHANNELS{serialized_conf[conf_idx]}};
            end
         end
         led_driver_pkg::SHIFT_REGISTER: begin
            // Chips 10 to 19 sit on layout 0
            for (int i = 0; i < `LED_NUM_CHANNELS; i++) begin
               if (i >= 10 && i < 20) begin
                  drivers_sin[i] = data_in[i][bit_sel0];
               end else begin
                  drivers_sin[i] = data_in[i][bit_sel1];
               end
            end
         end
         default: drivers_sin = '0;
      endcase
   end

   // End of each line, and once while idling for the bank that waits
   assign column_ready =
      (state == led_driver_pkg::SHIFT_REGISTER && wrtgs_cnt == SEG_LAST &&
       state_cnt == BIT_LAST) ||
      (state == led_driver_pkg::WAIT_FOR_NEXT_SLICE && state_cnt == IDLE_GCLK);

   // Falling-edge LAT lines up with the state it was computed from
   a_lat_blank: assert property (@(posedge clk) disable iff (!nrst)
      state == led_driver_pkg::BLANKING |-> !driver_lat);

   a_wrtfc_quiet: assert property (@(posedge clk) disable iff (!nrst)
      state == led_driver_pkg::WRTFC_TIMING |-> !driver_sclk && !driver_gclk);

endmodule

`default_nettype wire

// ==== source/column_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_driver_params.svh"

module column_buffer (
   input wire clk,
   input wire nrst,
   input wire clk_enable,
   input wire wr_en,
   input wire led_driver_pkg::chan_idx_t wr_chan,
   input wire led_driver_pkg::word_t wr_data,
   input wire column_ready,
   output led_driver_pkg::word_t data_in [`LED_NUM_CHANNELS]
);

   // Two banks, one shown to the sequencer and one filled by the host
   led_driver_pkg::word_t bank_mem [2][`LED_NUM_CHANNELS];

   // Selects the front bank, the back bank is its complement
   logic front_sel;
   logic back_sel;

   assign back_sel = ~front_sel;

   // Swap only on the enabled cycle the sequencer flags column_ready
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         front_sel <= 1'b0;
      end else if (column_ready && clk_enable) begin
         front_sel <= ~front_sel;
      end
   end

   // Host writes land in the back bank
   always_ff @(posedge clk) begin
      if (wr_en) begin
         bank_mem[back_sel][wr_chan] <= wr_data;
      end
   end

   // Front bank straight to the sequencer
   always_comb begin
      for (int i = 0; i < `LED_NUM_CHANNELS; i++) begin
         data_in[i] = bank_mem[front_sel][i];
      end
   end

   // Host must stay inside the chain
   a_chan_range: assert property (@(posedge clk) disable iff (!nrst)
      wr_en |-> (wr_chan < `LED_NUM_CHANNELS));

endmodule

`default_nettype wire

// ==== source/driver_config_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_driver_params.svh"

module driver_config_reg (
   input wire clk,
   input wire nrst,
   input wire clk_enable,
   input wire conf_wr,
   input wire led_driver_pkg::word_t conf_data,
   output led_driver_pkg::word_t serialized_conf,
   output logic new_configuration_ready
);

   led_driver_pkg::word_t conf_q;
   logic pending;

   // Function-control word, host write takes it over on the next edge
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         conf_q <= `LED_DEFAULT_CONF;
      end else if (conf_wr) begin
         conf_q <= conf_data;
      end
   end

   // Pending flag starts set so the default word goes out at boot
   // A write landing on an enabled cycle keeps it armed for the next one
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         pending <= 1'b1;
      end else if (conf_wr) begin
         pending <= 1'b1;
      end else if (clk_enable) begin
         pending <= 1'b0;
      end
   end

   // Pulse lines up with the enable so the sequencer cannot miss it
   assign new_configuration_ready = pending & clk_enable;
   assign serialized_conf = conf_q;

endmodule

`default_nettype wire

// ==== source/shift_enable_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_driver_params.svh"

module shift_enable_gen (
   input wire clk,
   input wire nrst,
   output logic clk_enable
);

   // Counter needs at least one bit even when dividing by one
   localparam int CNT_W = (`LED_CLK_DIV > 1) ? $clog2(`LED_CLK_DIV) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LED_CLK_DIV - 1);

   logic [CNT_W-1:0] div_cnt;

   // Strobe on wrap, first one comes LED_CLK_DIV cycles out of reset
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         div_cnt <= '0;
         clk_enable <= 1'b0;
      end else if (div_cnt == CNT_LAST) begin
         div_cnt <= '0;
         clk_enable <= 1'b1;
      end else begin
         div_cnt <= div_cnt + 1'b1;
         clk_enable <= 1'b0;
      end
   end

   // With a real divider the strobe is a single cycle wide
   a_single_strobe: assert property (@(posedge clk) disable iff (!nrst)
      (`LED_CLK_DIV > 1) && clk_enable |=> !clk_enable);

endmodule

`default_nettype wire

// ==== source/led_driver_pkg.sv ====
`default_nettype none

`include "led_driver_params.svh"

package led_driver_pkg;

   // One channel word, also the width of the function-control word
   typedef logic [`LED_WORD_BITS-1:0] word_t;

   // Index of one chip in the chain
   typedef logic [$clog2(`LED_NUM_CHANNELS)-1:0] chan_idx_t;

   // Chip command sequencer states
   // STALL is the reset state, the chips are unconfigured there
   typedef enum logic [3:0] {
      STALL,
      PREPARE_CONFIG,
      CONFIG,
      BLANKING,
      SHIFT_REGISTER,
      PAUSE_SCLK,
      PREPARE_DUMP_CONFIG,
      DUMP_CONFIG,
      WRTFC_TIMING,
      WAIT_FOR_NEXT_SLICE
   } seq_state_t;

endpackage

`default_nettype wire

// ==== source/led_driver_params.svh ====
`ifndef LED_DRIVER_PARAMS_SVH
`define LED_DRIVER_PARAMS_SVH

// Chips on the bank, one SIN line each
`define LED_NUM_CHANNELS 30
// Bits per channel word and per function-control word
`define LED_WORD_BITS 48
// Clk cycles per shift enable, any value from 1 up
`define LED_CLK_DIV 2

// Enabled cycles of blanking ahead of every multiplex line
`define LED_BLANKING_TIME 72
// WRTGS segments per line and lines per slice
`define LED_SEGMENTS_PER_LINE 10
`define LED_LINES_PER_SLICE 8
// GCLK pulses given out while idling between slices
`define LED_GCLK_IDLE 512

// Function-control word loaded at reset
`define LED_DEFAULT_CONF 48'h0001_5A00_3C3F

`endif
